//--- csi2_cfg.svh
`ifndef CSI2_CFG_SVH
`define CSI2_CFG_SVH

// Short packet data types handled by the frame tracker
`define CSI2_DT_FS        6'h00
`define CSI2_DT_FE        6'h01

// Data types from this code upwards announce a long packet
`define CSI2_DT_LONG_MIN  6'h10

// Width of the long packet count kept per frame
`define CSI2_FRAME_CNT_W  16

`endif

//--- csi2_frame_tracker.sv
`timescale 1ns/1ns
`default_nettype none
`include "csi2_cfg.svh"

module csi2_frame_tracker
  import csi2_hdr_pkg::*;
(
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          short_pkt_valid_i,
  input  wire short_pkt_t              short_pkt_i,
  input  wire                          long_hdr_valid_i,
  output logic                         frame_active_o,
  output logic                         frame_done_o,
  output logic [`CSI2_FRAME_CNT_W-1:0] frame_lines_o
);

  typedef enum logic {
    IDLE,
    IN_FRAME
  } state_t;

  state_t                        state;
  logic                          long_d1;
  logic                          long_rise;
  logic                          is_fs;
  logic                          is_fe;
  logic [`CSI2_FRAME_CNT_W-1:0]  line_cnt;

  // The long header valid is a level, one rise per packet
  assign long_rise = long_hdr_valid_i && !long_d1;
  assign is_fs     = short_pkt_valid_i && (short_pkt_i.dt == `CSI2_DT_FS);
  assign is_fe     = short_pkt_valid_i && (short_pkt_i.dt == `CSI2_DT_FE);

  assign frame_active_o = (state == IN_FRAME);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state        <= IDLE;
      long_d1      <= 1'b0;
      line_cnt     <= '0;
      frame_done_o <= 1'b0;
    end
    else
    begin
      long_d1      <= long_hdr_valid_i;
      frame_done_o <= 1'b0;
      case (state)
        IDLE:
        begin
          if (is_fs)
          begin
            state    <= IN_FRAME;
            line_cnt <= '0;
          end
        end
        IN_FRAME:
        begin
          // A repeated Frame Start restarts the count
          if (is_fs)
            line_cnt <= '0;
          else if (is_fe)
          begin
            frame_done_o <= 1'b1;
            state        <= IDLE;
          end
          else if (long_rise)
            line_cnt <= line_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (is_fe && frame_active_o)
      frame_lines_o <= line_cnt;
  end

endmodule

`default_nettype wire

//--- csi2_hdr_ecc.sv
`timescale 1ns/1ns
`default_nettype none

module csi2_hdr_ecc
  import csi2_stream_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_i,
  input  wire        valid_i,
  input  wire word_t data_i,
  output link_word_t word_o
);

  // Parity column of each header data bit, P5 in the top bit
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b
  };

  function automatic logic [5:0] calc_ecc(input logic [23:0] hdr);
    logic [5:0] ecc;
    ecc = '0;
    for (int i = 0; i < 24; i++)
    begin
      if (hdr[i])
        ecc = ecc ^ ECC_COL[i];
    end
    return ecc;
  endfunction

  logic [5:0]  syndrome;
  logic [23:0] flip;
  logic        data_err;
  logic        parity_err;
  logic        hdr_cand;

  always_comb
  begin
    syndrome = calc_ecc(data_i[23:0]) ^ data_i[29:24];
    flip     = '0;
    // At most one column can match the syndrome
    for (int i = 0; i < 24; i++)
    begin
      if (syndrome == ECC_COL[i])
        flip[i] = 1'b1;
    end
  end

  assign data_err   = |flip;
  assign parity_err = $onehot(syndrome);

  // Only the first word of a burst can be a header, and a header has bits 31:30 clear.
  // Payload words keep their bits; their flags are ignored downstream
  assign hdr_cand = valid_i && !word_o.valid && (data_i[31:30] == 2'b00);

  always_ff @(posedge clk_i)
  begin
    if (hdr_cand)
      word_o.data <= data_i ^ {8'h00, flip};
    else
      word_o.data <= data_i;
    word_o.error     <= valid_i && (syndrome != 6'h00);
    word_o.corrected <= valid_i && (data_err || parity_err);
    if (rst_i)
      word_o.valid <= 1'b0;
    else
      word_o.valid <= valid_i;
  end

endmodule

`default_nettype wire

//--- csi2_hdr_pkg.sv
`default_nettype none

package csi2_hdr_pkg;

  // Header fields
  typedef logic [1:0]  vc_t;
  typedef logic [5:0]  dt_t;
  typedef logic [15:0] wc_t;

  // Field order follows the header layout, so a cast of bits 23:0 fills the struct
  typedef struct packed {
    wc_t data;
    vc_t vc;
    dt_t dt;
  } short_pkt_t;

  typedef struct packed {
    wc_t wc;
    vc_t vc;
    dt_t dt;
  } long_hdr_t;

endpackage

`default_nettype wire

//--- csi2_pkt_handler.sv
`timescale 1ns/1ns
`default_nettype none
`include "csi2_cfg.svh"

module csi2_pkt_handler
  import csi2_hdr_pkg::*;
  import csi2_stream_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_i,
  input  wire link_word_t word_i,
  output logic            short_pkt_valid_o,
  output short_pkt_t      short_pkt_o,
  output logic            long_hdr_valid_o,
  output long_hdr_t       long_hdr_o,
  output logic            payload_valid_o,
  output payload_t        payload_o,
  // Tells the PHY side the packet is complete
  output logic            pkt_done_o
);

  logic  valid_d1;
  logic  done_d1;
  logic  pkt_running;
  logic  hdr_ok;
  logic  header_valid;
  logic  long_start;
  logic  short_start;
  logic  last_word;
  dt_t   hdr_dt;
  wc_t   byte_cnt;
  be_t   last_be;

  // With fewer lanes the valid strobe has holes, so a header is only
  // looked for on the first rising edge of valid
  assign hdr_dt       = word_i.data[5:0];
  assign hdr_ok       = !word_i.error || word_i.corrected;
  assign header_valid = word_i.valid && !valid_d1 && hdr_ok && !pkt_running;
  assign long_start   = header_valid && (hdr_dt >= `CSI2_DT_LONG_MIN);
  assign short_start  = header_valid && (hdr_dt < `CSI2_DT_LONG_MIN);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_d1 <= 1'b0;
      done_d1  <= 1'b0;
    end
    else
    begin
      valid_d1 <= word_i.valid;
      done_d1  <= pkt_done_o;
    end
  end

  // Only long packets have a body to run through
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pkt_running <= 1'b0;
    else if (long_start)
      pkt_running <= 1'b1;
    else if (pkt_done_o)
      pkt_running <= 1'b0;
  end

  // Payload is counted in whole words
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      byte_cnt <= '0;
    else if (pkt_done_o)
      byte_cnt <= '0;
    else if (word_i.valid && pkt_running)
      byte_cnt <= byte_cnt + 16'd4;
  end

  assign last_word  = ({1'b0, byte_cnt} + 17'd4) >= {1'b0, long_hdr_o.wc};
  assign pkt_done_o = last_word && pkt_running && word_i.valid;

  // Last word keeps the low wc mod 4 bytes, or all of them
  always_comb
  begin
    if (long_hdr_o.wc[1:0] == 2'd0)
      last_be = 4'hf;
    else
    begin
      for (int i = 0; i < 4; i++)
        last_be[i] = long_hdr_o.wc[1:0] > 2'(i);
    end
  end

  // Short packets
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      short_pkt_valid_o <= 1'b0;
    else
      short_pkt_valid_o <= short_start;
  end

  always_ff @(posedge clk_i)
  begin
    if (short_start)
      short_pkt_o <= short_pkt_t'(word_i.data[23:0]);
  end

  // Long header stays up until the cycle after done
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      long_hdr_valid_o <= 1'b0;
    else if (long_start)
      long_hdr_valid_o <= 1'b1;
    else if (done_d1)
      long_hdr_valid_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (long_start)
      long_hdr_o <= long_hdr_t'(word_i.data[23:0]);
  end

  // Payload stream
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      payload_valid_o <= 1'b0;
    else
      payload_valid_o <= word_i.valid && pkt_running;
  end

  always_ff @(posedge clk_i)
  begin
    payload_o.data <= word_i.data;
    payload_o.be   <= pkt_done_o ? last_be : 4'hf;
    payload_o.eop  <= pkt_done_o;
  end

endmodule

`default_nettype wire

//--- csi2_rx_props.sv
`timescale 1ns/1ns
`default_nettype none

module csi2_rx_props (
  input wire clk_i,
  input wire rst_i,
  input wire short_valid_i,
  input wire long_hdr_valid_i,
  input wire payload_valid_i,
  input wire eop_i,
  input wire pkt_done_i
);

  // A header is either short or long, never both at once
  short_long_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(short_valid_i && $rose(long_hdr_valid_i)))
    else $error("short strobe and long header rise in the same cycle");

  eop_with_payload: assert property (@(posedge clk_i) disable iff (rst_i)
    eop_i |-> payload_valid_i)
    else $error("eop without a payload strobe");

  // Done only closes a packet whose long header is published
  done_while_running: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_done_i |-> long_hdr_valid_i)
    else $error("packet done while no packet is running");

endmodule

bind csi2_pkt_handler csi2_rx_props csi2_rx_props_i (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .short_valid_i    (short_pkt_valid_o),
  .long_hdr_valid_i (long_hdr_valid_o),
  .payload_valid_i  (payload_valid_o),
  .eop_i            (payload_o.eop),
  .pkt_done_i       (pkt_done_o)
);

`default_nettype wire

//--- csi2_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "csi2_cfg.svh"

module csi2_rx_tb
  import csi2_hdr_pkg::*;
  import csi2_stream_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 40;
  // Header, worst case gaps, idle and waiting for one packet
  localparam int PKT_CYCLES   = 30;
  localparam int NUM_PKTS     = 20;
  localparam int RUN_CYCLES   = RESET_CYCLES + NUM_PKTS * PKT_CYCLES + 100;

  localparam int EV_SHORT = 0;
  localparam int EV_EOP   = 1;
  localparam int EV_FRAME = 2;

  // Parity equations of the CSI-2 header ECC, P0 first
  localparam logic [23:0] PARITY_MASK [6] = '{
    24'hf1_2cb7, 24'hf2_555b, 24'h74_9a6d, 24'hb8_e38e, 24'hdf_03f0, 24'hef_fc00
  };

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic                         valid_i;
  word_t                        data_i;
  logic                         short_pkt_valid_o;
  short_pkt_t                   short_pkt_o;
  logic                         long_hdr_valid_o;
  long_hdr_t                    long_hdr_o;
  logic                         payload_valid_o;
  payload_t                     payload_o;
  logic                         pkt_done_o;
  logic                         frame_active_o;
  logic                         frame_done_o;
  logic [`CSI2_FRAME_CNT_W-1:0] frame_lines_o;

  integer                       seed = 32'h3c1b_cb50;
  payload_t                     exp_q [$];
  long_hdr_t                    exp_hdr;
  int                           beat_idx = 0;
  int                           short_cnt = 0;
  int                           hdr_rise_cnt = 0;
  int                           eop_cnt = 0;
  int                           done_cnt = 0;
  int                           frame_cnt = 0;
  short_pkt_t                   last_short;
  logic [`CSI2_FRAME_CNT_W-1:0] last_lines;
  logic                         hdr_d1 = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  csi2_rx_top csi2_rx_top_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .valid_i           (valid_i),
    .data_i            (data_i),
    .short_pkt_valid_o (short_pkt_valid_o),
    .short_pkt_o       (short_pkt_o),
    .long_hdr_valid_o  (long_hdr_valid_o),
    .long_hdr_o        (long_hdr_o),
    .payload_valid_o   (payload_valid_o),
    .payload_o         (payload_o),
    .pkt_done_o        (pkt_done_o),
    .frame_active_o    (frame_active_o),
    .frame_done_o      (frame_done_o),
    .frame_lines_o     (frame_lines_o)
  );

  function automatic logic [5:0] header_ecc(input logic [23:0] hdr);
    logic [5:0] ecc;
    for (int p = 0; p < 6; p++)
      ecc[p] = ^(hdr & PARITY_MASK[p]);
    return ecc;
  endfunction

  function automatic word_t header_word(input vc_t vc, input dt_t dt, input wc_t wc);
    logic [23:0] hdr;
    hdr = {wc, vc, dt};
    return {2'b00, header_ecc(hdr), hdr};
  endfunction

  // Low wc mod 4 bytes on the last word, all four when it divides evenly
  function automatic be_t last_be(input wc_t wc);
    case (wc[1:0])
      2'd1: return 4'b0001;
      2'd2: return 4'b0011;
      2'd3: return 4'b0111;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic int event_count(input int which);
    case (which)
      EV_SHORT: return short_cnt;
      EV_EOP:   return eop_cnt;
      default:  return frame_cnt;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected)
      fail_run($sformatf("mismatch at %0t ns: %s, got %0h, expected %0h",
                         $time, what, actual, expected));
  endtask

  task automatic check_short(input vc_t vc, input dt_t dt, input wc_t data, input string what);
    check(64'(last_short), 64'({data, vc, dt}), what);
  endtask

  task automatic drive_word(input word_t w);
    valid_i = 1'b1;
    data_i  = w;
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_idle(input int cycles);
    valid_i = 1'b0;
    data_i  = '0;
    repeat (cycles)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_for(input int which, input int target, input string what);
    int waited;
    waited = 0;
    while (event_count(which) < target && waited < WAIT_LIMIT)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (event_count(which) < target)
      fail_run($sformatf("timed out waiting for %s", what));
  endtask

  task automatic send_short(input vc_t vc, input dt_t dt, input wc_t data, input word_t flip);
    drive_word(header_word(vc, dt, data) ^ flip);
    drive_idle(2);
  endtask

  // Expected beats are queued only for headers the DUT should accept
  task automatic send_long(input vc_t vc, input dt_t dt, input wc_t wc, input word_t flip,
                           input logic gaps, input logic accept);
    int       nwords;
    word_t    w;
    payload_t beat;
    nwords = (int'(wc) + 3) / 4;
    if (accept)
      exp_hdr = long_hdr_t'({wc, vc, dt});
    drive_word(header_word(vc, dt, wc) ^ flip);
    for (int i = 0; i < nwords; i++)
    begin
      if (gaps && (($random(seed) & 1) == 1))
        drive_idle(1);
      // Bit 31 set so a word after a gap is never taken for a header
      w         = 32'h8000_0000 | word_t'($random(seed));
      beat.data = w;
      beat.be   = (i == nwords - 1) ? last_be(wc) : 4'hf;
      beat.eop  = (i == nwords - 1);
      if (accept)
        exp_q.push_back(beat);
      drive_word(w);
    end
    drive_idle(2);
  endtask

  task automatic long_packet(input vc_t vc, input dt_t dt, input wc_t wc, input word_t flip);
    int eops;
    int dones;
    int rises;
    eops  = eop_cnt;
    dones = done_cnt;
    rises = hdr_rise_cnt;
    send_long(vc, dt, wc, flip, 1'b1, 1'b1);
    wait_for(EV_EOP, eops + 1, "end of long packet");
    drive_idle(2);
    check(64'(beat_idx), 64'(exp_q.size()), "payload words received");
    check(64'(done_cnt), 64'(dones + 1), "packet done pulses");
    check(64'(hdr_rise_cnt), 64'(rises + 1), "long header strobes");
    check(64'(long_hdr_valid_o), 64'd0, "long header released after packet");
  endtask

  task automatic check_beat();
    payload_t expected;
    if (beat_idx >= exp_q.size())
      fail_run("payload word arrived while no payload was expected");
    else
    begin
      expected = exp_q[beat_idx];
      beat_idx++;
      check(64'(payload_o), 64'(expected), "payload word");
      check(64'(long_hdr_valid_o), 64'd1, "long header valid during payload");
      check(64'(long_hdr_o), 64'(exp_hdr), "long header fields");
      if (payload_o.eop)
        eop_cnt++;
    end
  endtask

  // Outputs are sampled on the falling edge, away from any update
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (short_pkt_valid_o)
      begin
        short_cnt++;
        last_short = short_pkt_o;
      end
      if (long_hdr_valid_o && !hdr_d1)
        hdr_rise_cnt++;
      if (pkt_done_o)
        done_cnt++;
      if (frame_done_o)
      begin
        frame_cnt++;
        last_lines = frame_lines_o;
      end
      if (payload_valid_o)
        check_beat();
    end
    hdr_d1 = long_hdr_valid_o;
  end

  task automatic test_short_packet();
    int shorts;
    int rises;
    shorts = short_cnt;
    rises  = hdr_rise_cnt;
    send_short(2'd1, 6'h08, 16'hbeef, '0);
    wait_for(EV_SHORT, shorts + 1, "short packet strobe");
    drive_idle(4);
    check(64'(short_cnt), 64'(shorts + 1), "short strobe count");
    check_short(2'd1, 6'h08, 16'hbeef, "short packet fields");
    check(64'(hdr_rise_cnt), 64'(rises), "no long header for a short packet");
  endtask

  task automatic test_long_payload();
    for (int n = 8; n <= 11; n++)
      long_packet(2'd0, 6'h2a, wc_t'(n), '0);
  endtask

  task automatic test_ecc_correction();
    int shorts;
    shorts = short_cnt;
    // Data field bit 5 flipped
    send_short(2'd2, 6'h0a, 16'h5a3c, 32'h0000_2000);
    wait_for(EV_SHORT, shorts + 1, "corrected short packet");
    check_short(2'd2, 6'h0a, 16'h5a3c, "short fields after data bit correction");
    send_short(2'd3, 6'h0c, 16'h1234, 32'h0800_0000);
    wait_for(EV_SHORT, shorts + 2, "short packet with ECC bit error");
    check_short(2'd3, 6'h0c, 16'h1234, "short fields after ECC bit error");
    // Word count 10 would read as 8 without the correction
    long_packet(2'd1, 6'h2b, 16'd10, 32'h0000_0200);
  endtask

  task automatic test_bad_header();
    int shorts;
    int rises;
    int dones;
    shorts = short_cnt;
    rises  = hdr_rise_cnt;
    dones  = done_cnt;
    send_short(2'd0, 6'h09, 16'h0f0f, 32'h0010_0100);
    send_long(2'd0, 6'h2a, 16'd12, 32'h0000_0003, 1'b0, 1'b0);
    drive_idle(6);
    check(64'(short_cnt), 64'(shorts), "short strobe on a bad header");
    check(64'(hdr_rise_cnt), 64'(rises), "long header strobe on a bad header");
    check(64'(done_cnt), 64'(dones), "packet done on a bad header");
    send_short(2'd1, 6'h0b, 16'h00aa, '0);
    wait_for(EV_SHORT, shorts + 1, "short packet after a bad header");
    check_short(2'd1, 6'h0b, 16'h00aa, "short fields after a bad header");
    long_packet(2'd0, 6'h2a, 16'd12, '0);
  endtask

  task automatic test_frame_count();
    int shorts;
    int frames;
    frames = frame_cnt;
    long_packet(2'd0, 6'h2a, 16'd8, '0);
    check(64'(frame_active_o), 64'd0, "frame inactive before frame start");
    shorts = short_cnt;
    send_short(2'd0, `CSI2_DT_FS, 16'd1, '0);
    wait_for(EV_SHORT, shorts + 1, "frame start");
    check(64'(frame_active_o), 64'd1, "frame active after frame start");
    for (int i = 0; i < 3; i++)
      long_packet(2'd0, 6'h2a, wc_t'(16 + i), '0);
    send_short(2'd0, `CSI2_DT_FE, 16'd1, '0);
    wait_for(EV_FRAME, frames + 1, "frame done");
    check(64'(last_lines), 64'd3, "long packets counted in the frame");
    check(64'(frame_active_o), 64'd0, "frame inactive after frame end");
    long_packet(2'd0, 6'h2a, 16'd8, '0);
    check(64'(frame_active_o), 64'd0, "frame inactive after a stray long packet");
    // A Frame End with no frame open must not report a frame
    shorts = short_cnt;
    send_short(2'd0, `CSI2_DT_FE, 16'd2, '0);
    wait_for(EV_SHORT, shorts + 1, "frame end outside a frame");
    drive_idle(4);
    check(64'(frame_cnt), 64'(frames + 1), "frame done outside a frame");
    check(64'(frame_active_o), 64'd0, "frame inactive after a stray frame end");
  endtask

  initial
  begin
    rst_i   = 1'b1;
    valid_i = 1'b0;
    data_i  = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    check(64'({short_pkt_valid_o, long_hdr_valid_o, payload_valid_o, pkt_done_o,
               frame_done_o, frame_active_o}), 64'd0, "strobes low in reset");
    rst_i = 1'b0;
    drive_idle(2);
    test_short_packet();
    test_long_payload();
    test_ecc_correction();
    test_bad_header();
    test_frame_count();
    $display("All tests passed");
    $finish;
  end

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

//--- csi2_rx_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "csi2_cfg.svh"

module csi2_rx_top
  import csi2_hdr_pkg::*;
  import csi2_stream_pkg::*;
(
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          valid_i,
  input  wire word_t                   data_i,
  output logic                         short_pkt_valid_o,
  output short_pkt_t                   short_pkt_o,
  output logic                         long_hdr_valid_o,
  output long_hdr_t                    long_hdr_o,
  output logic                         payload_valid_o,
  output payload_t                     payload_o,
  output logic                         pkt_done_o,
  output logic                         frame_active_o,
  output logic                         frame_done_o,
  output logic [`CSI2_FRAME_CNT_W-1:0] frame_lines_o
);

  link_word_t link_word;

  csi2_hdr_ecc csi2_hdr_ecc_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .data_i  (data_i),
    .word_o  (link_word)
  );

  csi2_pkt_handler csi2_pkt_handler_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .word_i            (link_word),
    .short_pkt_valid_o (short_pkt_valid_o),
    .short_pkt_o       (short_pkt_o),
    .long_hdr_valid_o  (long_hdr_valid_o),
    .long_hdr_o        (long_hdr_o),
    .payload_valid_o   (payload_valid_o),
    .payload_o         (payload_o),
    .pkt_done_o        (pkt_done_o)
  );

  // Frame accounting runs off the handler's header strobes
  csi2_frame_tracker csi2_frame_tracker_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .short_pkt_valid_i (short_pkt_valid_o),
    .short_pkt_i       (short_pkt_o),
    .long_hdr_valid_i  (long_hdr_valid_o),
    .frame_active_o    (frame_active_o),
    .frame_done_o      (frame_done_o),
    .frame_lines_o     (frame_lines_o)
  );

endmodule

`default_nettype wire

//--- csi2_stream_pkg.sv
`default_nettype none

package csi2_stream_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  // Word as seen after the header ECC check
  typedef struct packed {
    logic  valid;
    word_t data;
    logic  error;
    logic  corrected;
  } link_word_t;

  // Payload beat; its valid strobe travels beside it
  typedef struct packed {
    word_t data;
    be_t   be;
    logic  eop;
  } payload_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+.
csi2_hdr_pkg.sv
csi2_stream_pkg.sv
csi2_hdr_ecc.sv
csi2_pkt_handler.sv
csi2_frame_tracker.sv
csi2_rx_top.sv
csi2_rx_props.sv
csi2_rx_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module csi2_rx_tb -f list.f -o csi2_rx_sim
./obj_dir/csi2_rx_sim
